//--- cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath sizes
`define DATA_W      16          // register and bus word
`define ADDR_W      16          // word address on the bus
`define REG_CNT     8           // r0 reads as zero
`define REG_IDX_W   3
`define SHAMT_W     4           // shift amount, low bits of operand 2

// instruction fields, msb first
`define OPC_W       4
`define OPC_MSB     15
`define OPC_LSB     12
`define RD_MSB      11          // dest, or store source for sw
`define RD_LSB      9
`define RS1_MSB     8
`define RS1_LSB     6
`define RS2_MSB     5
`define RS2_LSB     3
`define IMM_MSB     5           // signed immediate of addi, lw, sw
`define IMM_LSB     0
`define IMM_W       6

`endif

//--- cpu_pkg.sv
`default_nettype none
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`DATA_W-1:0]    data_t;      // data word or word address
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`DATA_W-1:0]    instr_t;     // instruction is one word wide

    typedef enum logic [`OPC_W-1:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_SHL  = 4'd6,
        OP_SHR  = 4'd7,
        OP_ADDI = 4'd8,
        OP_LW   = 4'd9,
        OP_SW   = 4'd10                         // 11..15 decode as no-op
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,                                // also address calc for lw/sw
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHL,
        ALU_SHR                                 // logical, zero fill
    } alu_op_e;

    typedef enum logic [1:0] {
        HAZD_NORMAL,                            // take the decoded instruction
        HAZD_NO_OP,                             // insert a bubble
        HAZD_RETRY                              // hold id_ex and ex/mem
    } hazd_ctl_e;

    typedef struct packed {
        logic read;
        logic write;
    } mem_ctl_t;

    typedef struct packed {
        logic     no_op;
        logic     reg_write_enable;             // never set for r0
        mem_ctl_t mem_ctl;
        alu_op_e  alu_op;
        data_t    operand_1;
        data_t    operand_2;                    // immediate when use_imm
        data_t    store_data;
        reg_idx_t reg_1_idx;
        reg_idx_t reg_2_idx;                    // rd field for sw
        reg_idx_t reg_dest_idx;
        logic     use_imm;
    } id_ex_t;

    typedef struct packed {
        logic     no_op;
        logic     reg_write_enable;
        mem_ctl_t mem_ctl;
        data_t    result;                       // alu result or bus address
        data_t    store_data;
        reg_idx_t reg_dest_idx;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
        data_t    data;
    } wb_t;

endpackage

`default_nettype wire

//--- reg_file.sv
`default_nettype none
`include "cpu_params.svh"

module reg_file import cpu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire reg_idx_t rd_idx_1,
    input  wire reg_idx_t rd_idx_2,
    output data_t         rd_data_1,
    output data_t         rd_data_2,
    input  wire wb_t      wb                        // retired write from mem/wb
);

    data_t regs [`REG_CNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.idx != '0) begin
            regs[wb.idx] <= wb.data;                // r0 is never written
        end
    end

    // same-cycle write is passed through to the reader
    always_comb begin
        if (rd_idx_1 == '0)                         rd_data_1 = '0;
        else if (wb.valid && wb.idx == rd_idx_1)    rd_data_1 = wb.data;
        else                                        rd_data_1 = regs[rd_idx_1];

        if (rd_idx_2 == '0)                         rd_data_2 = '0;
        else if (wb.valid && wb.idx == rd_idx_2)    rd_data_2 = wb.data;
        else                                        rd_data_2 = regs[rd_idx_2];
    end

endmodule

`default_nettype wire

//--- decode_unit.sv
`default_nettype none
`include "cpu_params.svh"

module decode_unit import cpu_pkg::*; (
    input  wire instr_t   instr,
    input  wire logic     instr_valid,
    output reg_idx_t      rd_idx_1,                 // to reg_file
    output reg_idx_t      rd_idx_2,
    input  wire data_t    rd_data_1,
    input  wire data_t    rd_data_2,
    output id_ex_t        id                        // to hazard_unit and id_ex_reg
);

    opcode_e  opc;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    data_t    imm;
    logic     is_sw;

    assign opc   = opcode_e'(instr[`OPC_MSB:`OPC_LSB]);
    assign rd    = instr[`RD_MSB:`RD_LSB];
    assign rs1   = instr[`RS1_MSB:`RS1_LSB];
    assign rs2   = instr[`RS2_MSB:`RS2_LSB];
    assign imm   = {{(`DATA_W - `IMM_W){instr[`IMM_MSB]}}, instr[`IMM_MSB:`IMM_LSB]};
    assign is_sw = (opc == OP_SW);

    assign rd_idx_1 = rs1;
    assign rd_idx_2 = is_sw ? rd : rs2;             // sw reads its store source here

    always_comb begin
        id                  = '0;
        id.no_op            = 1'b1;                 // unknown opcodes fall out as bubbles
        id.alu_op           = ALU_ADD;
        case (opc)
            OP_ADD:  begin id.no_op = 1'b0; id.reg_write_enable = 1'b1; id.alu_op = ALU_ADD; end
            OP_SUB:  begin id.no_op = 1'b0; id.reg_write_enable = 1'b1; id.alu_op = ALU_SUB; end
            OP_AND:  begin id.no_op = 1'b0; id.reg_write_enable = 1'b1; id.alu_op = ALU_AND; end
            OP_OR:   begin id.no_op = 1'b0; id.reg_write_enable = 1'b1; id.alu_op = ALU_OR;  end
            OP_XOR:  begin id.no_op = 1'b0; id.reg_write_enable = 1'b1; id.alu_op = ALU_XOR; end
            OP_SHL:  begin id.no_op = 1'b0; id.reg_write_enable = 1'b1; id.alu_op = ALU_SHL; end
            OP_SHR:  begin id.no_op = 1'b0; id.reg_write_enable = 1'b1; id.alu_op = ALU_SHR; end
            OP_ADDI: begin id.no_op = 1'b0; id.reg_write_enable = 1'b1; id.use_imm = 1'b1; end
            OP_LW:   begin
                id.no_op            = 1'b0;
                id.reg_write_enable = 1'b1;
                id.mem_ctl.read     = 1'b1;
                id.use_imm          = 1'b1;         // address = rs1 + imm
            end
            OP_SW:   begin
                id.no_op            = 1'b0;
                id.mem_ctl.write    = 1'b1;
                id.use_imm          = 1'b1;
            end
            default: ;
        endcase

        id.reg_1_idx    = rs1;
        id.reg_2_idx    = id.use_imm ? (is_sw ? rd : '0) : rs2;    // '0 never matches a hazard
        id.reg_dest_idx = is_sw ? '0 : rd;
        id.operand_1    = rd_data_1;
        id.operand_2    = id.use_imm ? imm : rd_data_2;
        id.store_data   = rd_data_2;

        if (rd == '0) id.reg_write_enable = 1'b0;   // writes to r0 vanish here

        if (!instr_valid || id.no_op) begin         // a bubble carries no controls
            id.no_op            = 1'b1;
            id.reg_write_enable = 1'b0;
            id.mem_ctl          = '0;
        end
    end

endmodule

`default_nettype wire

//--- hazard_unit.sv
`default_nettype none

module hazard_unit import cpu_pkg::*; (
    input  wire id_ex_t   id_src,                   // instruction being offered
    input  wire id_ex_t   ex_cur,                   // contents of id_ex
    input  wire logic     mem_busy,                 // bus access outstanding
    output hazd_ctl_e     hazd_ctl,
    output logic          instr_ready
);

    logic live_load;
    logic load_use;
    logic mem_in_ex;

    assign live_load = !ex_cur.no_op && ex_cur.mem_ctl.read && ex_cur.reg_dest_idx != '0;

    // loaded value is not forwarded from ex/mem, only from write-back
    assign load_use  = live_load && !id_src.no_op &&
                       (ex_cur.reg_dest_idx == id_src.reg_1_idx ||
                        ex_cur.reg_dest_idx == id_src.reg_2_idx);

    // any access gets a bubble behind it so no real instruction sits in
    // id_ex while the bus stalls, its write-back operands would expire
    assign mem_in_ex = !ex_cur.no_op && (ex_cur.mem_ctl.read || ex_cur.mem_ctl.write);

    always_comb begin
        if (mem_busy)                   hazd_ctl = HAZD_RETRY;
        else if (load_use || mem_in_ex) hazd_ctl = HAZD_NO_OP;
        else                            hazd_ctl = HAZD_NORMAL;
    end

    assign instr_ready = (hazd_ctl == HAZD_NORMAL);   // only NORMAL consumes

endmodule

`default_nettype wire

//--- id_ex_reg.sv
`default_nettype none

module id_ex_reg import cpu_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire hazd_ctl_e hazd_ctl,                // from hazard_unit
    input  wire id_ex_t    id,                      // from decode_unit
    output id_ex_t         ex                       // to ex_stage, hazard_unit
);

    logic held_real;

    // bubbles never carry controls, so any control bit marks a real entry
    assign held_real = ex.reg_write_enable | ex.mem_ctl.read | ex.mem_ctl.write;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex       <= '0;
            ex.no_op <= 1'b1;                       // empty pipe after reset
        end else begin
            case (hazd_ctl)
                HAZD_NORMAL: ex <= id;
                HAZD_NO_OP: begin
                    ex.no_op            <= 1'b1;
                    ex.reg_write_enable <= 1'b0;    // old entry must not revive on retry
                    ex.mem_ctl          <= '0;
                end
                HAZD_RETRY:
                    ex.no_op            <= ~held_real;
                default:
                    ex.no_op            <= 1'b1;
            endcase
        end
    end

    // the bubble behind each access means retry only ever holds a bubble
    a_retry_holds_bubble: assert property (
        @(posedge clk) disable iff (!rst_n)
        hazd_ctl == HAZD_RETRY |-> ex.no_op
    );

endmodule

`default_nettype wire

//--- ex_stage.sv
`default_nettype none
`include "cpu_params.svh"

module ex_stage import cpu_pkg::*; (
    input  wire id_ex_t  ex,                        // from id_ex_reg
    input  wire ex_mem_t fwd_mem,                   // current ex/mem contents
    input  wire wb_t     fwd_wb,                    // current mem/wb contents
    output ex_mem_t      ex_out                     // to mem_stage
);

    // youngest producer wins, loads in ex/mem have no value yet
    function automatic data_t fwd(input reg_idx_t idx, input data_t dec,
                                  input ex_mem_t m, input wb_t w);
        logic mem_hit;
        logic wb_hit;
        mem_hit = !m.no_op && m.reg_write_enable && !m.mem_ctl.read &&
                  m.reg_dest_idx == idx;
        wb_hit  = w.valid && w.idx == idx;
        if (mem_hit)     return m.result;
        else if (wb_hit) return w.data;
        else             return dec;
    endfunction

    data_t op_1;
    data_t op_2;
    data_t st_data;
    data_t result;

    assign op_1    = fwd(ex.reg_1_idx, ex.operand_1, fwd_mem, fwd_wb);
    assign op_2    = ex.use_imm ? ex.operand_2      // immediate wins over any forward
                                : fwd(ex.reg_2_idx, ex.operand_2, fwd_mem, fwd_wb);
    assign st_data = fwd(ex.reg_2_idx, ex.store_data, fwd_mem, fwd_wb);

    always_comb begin
        case (ex.alu_op)
            ALU_ADD: result = op_1 + op_2;
            ALU_SUB: result = op_1 - op_2;
            ALU_AND: result = op_1 & op_2;
            ALU_OR:  result = op_1 | op_2;
            ALU_XOR: result = op_1 ^ op_2;
            ALU_SHL: result = op_1 << op_2[`SHAMT_W-1:0];
            ALU_SHR: result = op_1 >> op_2[`SHAMT_W-1:0];
            default: result = '0;
        endcase
    end

    always_comb begin
        ex_out.no_op            = ex.no_op;
        ex_out.reg_write_enable = ex.reg_write_enable;
        ex_out.mem_ctl          = ex.mem_ctl;
        ex_out.result           = result;           // word address for lw/sw
        ex_out.store_data       = st_data;
        ex_out.reg_dest_idx     = ex.reg_dest_idx;
    end

endmodule

`default_nettype wire

//--- mem_stage.sv
`default_nettype none
`include "cpu_params.svh"

module mem_stage import cpu_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire ex_mem_t ex_out,                    // from ex_stage
    output ex_mem_t      mem_cur,                   // ex/mem contents, forwarded
    output logic         mem_busy,                  // holds the front of the pipe
    output wb_t          wb,                        // retired write
    output logic         wb_cyc,
    output logic         wb_stb,
    output logic         wb_we,
    output data_t        wb_adr,
    output data_t        wb_dat_o,
    input  wire data_t   wb_dat_i,
    input  wire logic    wb_ack
);

    typedef enum logic {
        IDLE,
        WAIT                                        // request on the bus
    } wb_state_e;

    wb_state_e state_q;
    ex_mem_t   ex_mem_q;
    wb_t       wb_q;
    logic      pending;
    logic      done;

    assign pending  = !ex_mem_q.no_op && (ex_mem_q.mem_ctl.read || ex_mem_q.mem_ctl.write);
    assign done     = (state_q == WAIT) && wb_ack;
    assign mem_busy = pending && !done;             // low in the ack cycle, so it advances

    // ex/mem register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_q       <= '0;
            ex_mem_q.no_op <= 1'b1;
        end else if (!mem_busy) begin
            ex_mem_q       <= ex_out;
        end
    end

    // bus master with one request at a time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    if (pending) state_q <= WAIT;
                WAIT:    if (wb_ack)  state_q <= IDLE;     // cyc drops next cycle
                default: state_q <= IDLE;
            endcase
        end
    end

    // request fields come straight from ex/mem, which holds until ack
    assign wb_cyc   = (state_q == WAIT);
    assign wb_stb   = (state_q == WAIT);
    assign wb_we    = ex_mem_q.mem_ctl.write;
    assign wb_adr   = data_t'(ex_mem_q.result[`ADDR_W-1:0]);
    assign wb_dat_o = ex_mem_q.store_data;

    // mem/wb register with one valid cycle per retired write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_q <= '0;
        end else if (mem_busy) begin
            wb_q.valid <= 1'b0;                     // bubble while the bus waits
        end else begin
            wb_q.valid <= !ex_mem_q.no_op && ex_mem_q.reg_write_enable;
            wb_q.idx   <= ex_mem_q.reg_dest_idx;
            wb_q.data  <= ex_mem_q.mem_ctl.read ? wb_dat_i : ex_mem_q.result;
        end
    end

    assign mem_cur = ex_mem_q;
    assign wb      = wb_q;

    // request must not move until the slave has answered
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb_cyc && !wb_ack) |=> wb_cyc && $stable(wb_adr) && $stable(wb_we) &&
                                $stable(wb_dat_o)
    );

endmodule

`default_nettype wire

//--- core_top.sv
`default_nettype none

module core_top import cpu_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire instr_t instr,                      // instruction stream
    input  wire logic   instr_valid,
    output logic        instr_ready,
    output wb_t         wb,                         // retired register writes
    output logic        wb_cyc,                     // wishbone classic master
    output logic        wb_stb,
    output logic        wb_we,
    output data_t       wb_adr,
    output data_t       wb_dat_o,
    input  wire data_t  wb_dat_i,
    input  wire logic   wb_ack
);

    reg_idx_t  rd_idx_1;
    reg_idx_t  rd_idx_2;
    data_t     rd_data_1;
    data_t     rd_data_2;
    id_ex_t    id;                                  // decoded, not yet registered
    id_ex_t    ex;                                  // id_ex contents
    hazd_ctl_e hazd_ctl;
    ex_mem_t   ex_out;
    ex_mem_t   mem_cur;
    logic      mem_busy;

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_idx_1  (rd_idx_1),
        .rd_idx_2  (rd_idx_2),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2),
        .wb        (wb)
    );

    decode_unit u_decode_unit (
        .instr       (instr),
        .instr_valid (instr_valid),
        .rd_idx_1    (rd_idx_1),
        .rd_idx_2    (rd_idx_2),
        .rd_data_1   (rd_data_1),
        .rd_data_2   (rd_data_2),
        .id          (id)
    );

    hazard_unit u_hazard_unit (
        .id_src      (id),
        .ex_cur      (ex),
        .mem_busy    (mem_busy),
        .hazd_ctl    (hazd_ctl),
        .instr_ready (instr_ready)
    );

    id_ex_reg u_id_ex_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .hazd_ctl (hazd_ctl),
        .id       (id),
        .ex       (ex)
    );

    ex_stage u_ex_stage (
        .ex      (ex),
        .fwd_mem (mem_cur),
        .fwd_wb  (wb),
        .ex_out  (ex_out)
    );

    mem_stage u_mem_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_out   (ex_out),
        .mem_cur  (mem_cur),
        .mem_busy (mem_busy),
        .wb       (wb),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_o (wb_dat_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack)
    );

endmodule

`default_nettype wire

//--- core_tb.sv
`default_nettype none

module core_tb import cpu_pkg::*; ;

    timeunit 1ns;
    timeprecision 100ps;

    logic     clk;
    logic     rst_n;
    instr_t   instr;
    logic     instr_valid;
    logic     instr_ready;
    wb_t      wb;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    data_t    wb_adr;
    data_t    wb_dat_o;
    data_t    wb_dat_i;
    logic     wb_ack;

    data_t    mem [64];                             // bus slave memory
    data_t    ref_mem [64];                         // reference model state
    data_t    ref_regs [8];
    reg_idx_t exp_idx [$];                          // expected write-backs in program order
    data_t    exp_dat [$];
    data_t    st_adr [$];                           // expected stores in program order
    data_t    st_dat [$];
    logic [31:0] drv_lfsr;
    logic [31:0] ack_lfsr;
    int       n_issued;
    int       cycles;
    int       err_cnt;
    logic     in_req;                               // slave is serving a request
    int       wait_left;
    data_t    cap_adr;                              // request as first seen
    logic     cap_we;
    data_t    cap_dat;

    core_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .wb          (wb),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_o    (wb_dat_o),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                      // 4 ns period
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v     = {v[30:0], state[0]};
            state = state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
        end
        return v;
    endfunction

    function automatic data_t fill_word(input int a);
        return data_t'(16'h3c00 ^ (a * 16'h0421));  // distinct for every address
    endfunction

    function automatic instr_t enc_r(input opcode_e op, input reg_idx_t rd,
                                     input reg_idx_t rs1, input reg_idx_t rs2);
        return {op, rd, rs1, rs2, 3'b000};
    endfunction

    function automatic instr_t enc_i(input opcode_e op, input reg_idx_t rd,
                                     input reg_idx_t rs1, input logic [5:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    task automatic stop_on_error(input string why);
        err_cnt++;
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "first error, run stopped");
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_word(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_wb(input reg_idx_t idx, input data_t data);
        reg_idx_t e_idx;
        data_t    e_dat;
        if (exp_idx.size() == 0) begin
            stop_on_error($sformatf("write-back to r%0d arrived with no write pending", idx));
        end else begin
            e_idx = exp_idx.pop_front();
            e_dat = exp_dat.pop_front();
            if (idx !== e_idx) begin
                stop_on_error($sformatf("FAILED wb.idx: got %h, expected %h", idx, e_idx));
            end
            compare_word("wb.data", data, e_dat);
        end
    endtask

    task automatic compare_mem(input data_t adr, input data_t dat);
        if (st_adr.size() == 0) begin
            stop_on_error($sformatf("bus write to %h with no store pending", adr));
        end else begin
            compare_word("wb_adr", adr, st_adr.pop_front());
            compare_word("wb_dat_o", dat, st_dat.pop_front());
        end
    endtask

    // reference model run once per accepted instruction
    task automatic ref_exec(input instr_t i);
        opcode_e  opc;
        reg_idx_t rd;
        data_t    a;
        data_t    b;
        data_t    imm;
        data_t    adr;
        data_t    v;
        logic     wr;
        opc = opcode_e'(i[15:12]);
        rd  = i[11:9];
        a   = ref_regs[i[8:6]];
        b   = ref_regs[i[5:3]];
        imm = {{10{i[5]}}, i[5:0]};
        adr = a + imm;
        wr  = 1'b1;
        v   = '0;
        case (opc)
            OP_ADD:  v = a + b;
            OP_SUB:  v = a - b;
            OP_AND:  v = a & b;
            OP_OR:   v = a | b;
            OP_XOR:  v = a ^ b;
            OP_SHL:  v = a << b[3:0];
            OP_SHR:  v = a >> b[3:0];
            OP_ADDI: v = adr;
            OP_LW:   v = ref_mem[adr[5:0]];
            OP_SW: begin
                wr = 1'b0;
                st_adr.push_back(adr);
                st_dat.push_back(ref_regs[rd]);
                ref_mem[adr[5:0]] = ref_regs[rd];
            end
            default: wr = 1'b0;                     // nop and unused opcodes
        endcase
        if (wr && rd != 3'd0) begin
            ref_regs[rd] = v;
            exp_idx.push_back(rd);
            exp_dat.push_back(v);
        end
    endtask

    // offer one instruction until the core takes it
    task automatic issue(input instr_t i);
        logic taken;
        instr       = i;
        instr_valid = 1'b1;
        taken       = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = instr_ready;
            @(posedge clk);
            #1;
        end
        n_issued++;
        ref_exec(i);
    endtask

    task automatic idle(input int n);
        instr_valid = 1'b0;
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic drain();
        instr_valid = 1'b0;
        while (exp_idx.size() != 0 || st_adr.size() != 0) @(posedge clk);
        repeat (8) @(posedge clk);                  // a stray write-back would show here
        #1;
    endtask

    task automatic test_reset();
        @(negedge clk);
        compare_bit("instr_ready", instr_ready, 1'b1);
        compare_bit("wb.valid", wb.valid, 1'b0);
        compare_bit("wb_cyc", wb_cyc, 1'b0);
        @(posedge clk);
        #1;
        for (int r = 1; r < 8; r++) begin
            issue(enc_r(OP_ADD, reg_idx_t'(r), reg_idx_t'(r), reg_idx_t'(r)));
        end
        drain();
    endtask

    task automatic test_alu();
        issue(enc_i(OP_ADDI, 3'd1, 3'd0, 6'd13));
        issue(enc_i(OP_ADDI, 3'd2, 3'd0, 6'h39));  // -7
        idle(4);
        for (int k = 1; k <= 7; k++) begin
            issue(enc_r(opcode_e'(k), reg_idx_t'(3 + k % 5), 3'd1, 3'd2));
            idle(4);                                // operands come from the register file
        end
        issue(enc_r(OP_SUB, 3'd0, 3'd1, 3'd2));    // no write-back expected
        issue(enc_i(OP_ADDI, 3'd0, 3'd1, 6'd5));
        issue(enc_i(OP_ADDI, 3'd3, 3'd0, 6'h20));  // most negative immediate
        issue(enc_r(OP_SHR, 3'd4, 3'd3, 3'd1));    // zero fill from the top
        drain();
    endtask

    task automatic test_forward();
        issue(enc_i(OP_ADDI, 3'd1, 3'd0, 6'd5));
        issue(enc_i(OP_ADDI, 3'd2, 3'd1, 6'd3));   // r1 from ex/mem
        issue(enc_r(OP_ADD, 3'd3, 3'd2, 3'd1));    // r2 from ex/mem, r1 from write-back
        issue(enc_r(OP_SUB, 3'd4, 3'd3, 3'd1));
        issue(enc_r(OP_XOR, 3'd5, 3'd4, 3'd3));
        issue(enc_r(OP_SHL, 3'd6, 3'd5, 3'd1));
        issue(enc_r(OP_OR, 3'd6, 3'd6, 3'd6));     // same dest twice in flight
        issue(enc_i(OP_SW, 3'd6, 3'd0, 6'd3));     // store data forwarded
        drain();
    endtask

    task automatic test_mem();
        issue(enc_i(OP_ADDI, 3'd4, 3'd0, 6'd30));
        for (int k = 0; k < 6; k++) begin
            issue(enc_i(OP_ADDI, 3'd1, 3'd0, 6'(k * 7 + 1)));
            issue(enc_i(OP_SW, 3'd1, 3'd0, 6'(k + 16)));
            issue(enc_i(OP_LW, 3'd2, 3'd0, 6'(k + 16)));
            issue(enc_i(OP_SW, 3'd1, 3'd4, 6'h3e));    // negative offset, r4 - 2
            issue(enc_i(OP_LW, 3'd5, 3'd4, 6'h3e));
        end
        drain();
    endtask

    task automatic test_load_use();
        issue(enc_i(OP_LW, 3'd3, 3'd0, 6'd20));
        issue(enc_r(OP_ADD, 3'd4, 3'd3, 3'd3));    // needs the loaded word at once
        issue(enc_i(OP_LW, 3'd5, 3'd0, 6'd9));
        issue(enc_i(OP_SW, 3'd5, 3'd0, 6'd11));    // loaded word as store data
        issue(enc_i(OP_LW, 3'd6, 3'd5, 6'd1));     // loaded word as address
        issue(enc_r(OP_SUB, 3'd7, 3'd6, 3'd4));
        drain();
    endtask

    task automatic test_random();
        for (int k = 0; k < 200; k++) begin
            issue(instr_t'(take_bits(drv_lfsr, 16)));
            if (take_bits(drv_lfsr, 2) == 0) idle(1 + int'(take_bits(drv_lfsr, 2)));
        end
        drain();
        for (int a = 0; a < 64; a++) begin
            compare_word($sformatf("mem[%0d]", a), mem[a], ref_mem[a]);
        end
    endtask

    // wishbone slave with 0 to 3 wait cycles
    initial begin
        wb_ack    = 1'b0;
        wb_dat_i  = '0;
        in_req    = 1'b0;
        wait_left = 0;
        ack_lfsr  = 32'h7432;
        for (int a = 0; a < 64; a++) mem[a] = fill_word(a);
        forever begin
            @(posedge clk);
            #1;
            compare_bit("wb_stb", wb_stb, wb_cyc);  // stb travels with cyc
            if (wb_ack) begin
                compare_bit("wb_cyc", wb_cyc, 1'b0);    // dropped in the cycle after ack
                wb_ack = 1'b0;                      // single cycle ack
            end else if (wb_cyc && wb_stb) begin
                if (!in_req) begin
                    in_req    = 1'b1;
                    wait_left = int'(take_bits(ack_lfsr, 2));
                    cap_adr   = wb_adr;
                    cap_we    = wb_we;
                    cap_dat   = wb_dat_o;
                end else begin
                    compare_word("wb_adr", wb_adr, cap_adr);
                    compare_bit("wb_we", wb_we, cap_we);
                    compare_word("wb_dat_o", wb_dat_o, cap_dat);
                end
                if (wait_left == 0) begin
                    if (wb_we) begin
                        compare_mem(wb_adr, wb_dat_o);
                        mem[wb_adr[5:0]] = wb_dat_o;
                    end else begin
                        wb_dat_i = mem[wb_adr[5:0]];
                    end
                    wb_ack = 1'b1;
                    in_req = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // write-back monitor sampling at the falling edge where wb has settled
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && wb.valid) compare_wb(wb.idx, wb.data);
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 40 * n_issued + 200) begin
                stop_on_error("timeout, the core stopped taking or retiring instructions");
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        drv_lfsr    = 32'h7432;
        n_issued    = 0;
        err_cnt     = 0;
        for (int a = 0; a < 64; a++) ref_mem[a] = fill_word(a);
        for (int r = 0; r < 8; r++) ref_regs[r] = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_alu();
        test_forward();
        test_mem();
        test_load_use();
        test_random();
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
cpu_pkg.sv
reg_file.sv
decode_unit.sv
hazard_unit.sv
id_ex_reg.sv
ex_stage.sv
mem_stage.sv
core_top.sv
core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module core_tb \
    -o core_tb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/core_tb_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

# the verdict comes from the log
if grep -q "Simulation finished: FAIL" "$SIM_LOG"; then
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

exit 0
